/* design/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

        localparam int STEP_W = 3;
        localparam logic [STEP_W-1:0] FETCH_STEPS    = 3'd5;
        localparam logic [STEP_W-1:0] DECODE_STEPS   = 3'd2;
        localparam logic [STEP_W-1:0] MEM_WAIT_STEPS = 3'd2;
        localparam logic [STEP_W-1:0] EXC_STEPS      = 3'd3;
        localparam logic [4:0]        LINK_REG       = 5'd31;  // $ra

        typedef enum logic [5:0] {
                OP_RTYPE = 6'h00, OP_J   = 6'h02, OP_JAL  = 6'h03,
                OP_BEQ   = 6'h04, OP_BNE = 6'h05, OP_BLE  = 6'h06,
                OP_BGT   = 6'h07, OP_ADDI = 6'h08, OP_ADDIU = 6'h09,
                OP_LB    = 6'h20, OP_LH  = 6'h21, OP_LW   = 6'h23,
                OP_SB    = 6'h28, OP_SH  = 6'h29, OP_SW   = 6'h2b
        } opcode_t;

        typedef enum logic [5:0] {
                FN_ADD = 6'h20, FN_SUB = 6'h22, FN_AND = 6'h24, FN_SLT = 6'h2a
        } funct_t;

        typedef enum logic [3:0] {
                CLS_R_ALU, CLS_ADDI, CLS_ADDIU, CLS_BRANCH, CLS_LOAD,
                CLS_STORE, CLS_JUMP, CLS_JUMP_LINK, CLS_INVALID
        } instr_class_t;

        typedef enum logic [1:0] {COND_EQ, COND_NE, COND_LE, COND_GT} branch_cond_t;

        // Same encoding drives load_ctrl and store_ctrl
        typedef enum logic [1:0] {MW_WORD, MW_HALF, MW_BYTE} mem_width_t;

        typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_SLT, ALU_CMP} alu_op_t;

        typedef enum logic [3:0] {
                ST_FETCH, ST_DECODE, ST_R_EXEC, ST_R_WRITE, ST_ADDI_EXEC,
                ST_ADDI_WRITE, ST_BRANCH_CMP, ST_BRANCH_WRITE, ST_MEM_ADDR,
                ST_MEM_WAIT, ST_LOAD_WRITE, ST_STORE_WRITE, ST_JAL_LINK,
                ST_JUMP, ST_EXCEPTION
        } ctrl_state_t;

        typedef enum logic [1:0] {PC_ALU, PC_ALU_OUT, PC_JUMP, PC_LOAD} pc_src_t;
        typedef enum logic [1:0] {A_PC, A_REG} alu_src_a_t;
        typedef enum logic [1:0] {B_REG, B_FOUR, B_IMM, B_OFFSET} alu_src_b_t;

        // Memory address select, exception vectors included
        typedef enum logic [2:0] {
                IORD_PC = 3'd0, IORD_ALU = 3'd1, IORD_VEC_INV = 3'd2, IORD_VEC_OVF = 3'd3
        } iord_t;

        // Cause value doubles as its vector select in iord_t
        typedef enum logic [2:0] {
                EXC_INVALID = 3'd2, EXC_OVERFLOW = 3'd3
        } exc_cause_t;

        typedef enum logic [2:0] {RD_RT, RD_RD, RD_LINK} reg_dst_t;
        typedef enum logic [2:0] {DATA_ALU_OUT, DATA_MDR, DATA_PC} reg_data_t;

        typedef struct packed {
                logic overflow;
                logic gt;
                logic eq;
        } alu_flags_t;

        typedef struct packed {
                pc_src_t    pc_src;
                alu_src_a_t alu_src_a;
                alu_src_b_t alu_src_b;
                alu_op_t    alu_op;
                iord_t      iord;
                reg_dst_t   reg_dst;
                reg_data_t  reg_data;
                mem_width_t load_ctrl;
                mem_width_t store_ctrl;
                logic       mem_write;
                logic       ir_write;
                logic       pc_write;
                logic       bank_write;
                logic       epc_write;
                logic       a_write;
                logic       b_write;
                logic       alu_out_write;
                logic       mem_reg_write;
        } ctrl_word_t;

endpackage

/* design/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
        input  mips_ctrl_pkg::opcode_t      op,
        input  mips_ctrl_pkg::funct_t       funct,
        output mips_ctrl_pkg::instr_class_t cls,
        output mips_ctrl_pkg::alu_op_t      alu_op,
        output mips_ctrl_pkg::mem_width_t   mem_width,
        output mips_ctrl_pkg::branch_cond_t branch_cond
);
        import mips_ctrl_pkg::*;

        always_comb begin
                cls         = CLS_INVALID;     // Anything unlisted traps
                alu_op      = ALU_ADD;
                mem_width   = MW_WORD;
                branch_cond = COND_EQ;
                case (op)
                        OP_RTYPE: begin
                                cls = CLS_R_ALU;
                                case (funct)
                                        FN_ADD:  alu_op = ALU_ADD;
                                        FN_SUB:  alu_op = ALU_SUB;
                                        FN_AND:  alu_op = ALU_AND;
                                        FN_SLT:  alu_op = ALU_SLT;
                                        default: cls = CLS_INVALID;
                                endcase
                        end
                        OP_ADDI:                        cls = CLS_ADDI;
                        OP_ADDIU:                       cls = CLS_ADDIU;
                        OP_BEQ, OP_BNE, OP_BLE, OP_BGT: cls = CLS_BRANCH;
                        OP_LB, OP_LH, OP_LW:            cls = CLS_LOAD;
                        OP_SB, OP_SH, OP_SW:            cls = CLS_STORE;
                        OP_J:                           cls = CLS_JUMP;
                        OP_JAL:                         cls = CLS_JUMP_LINK;
                        default:                        cls = CLS_INVALID;
                endcase

                // Branch compare and access width
                case (op)
                        OP_BEQ: alu_op = ALU_CMP;
                        OP_BNE: begin
                                alu_op      = ALU_CMP;
                                branch_cond = COND_NE;
                        end
                        OP_BLE: begin
                                alu_op      = ALU_CMP;
                                branch_cond = COND_LE;
                        end
                        OP_BGT: begin
                                alu_op      = ALU_CMP;
                                branch_cond = COND_GT;
                        end
                        OP_LB, OP_SB: mem_width = MW_BYTE;
                        OP_LH, OP_SH: mem_width = MW_HALF;
                        default:      mem_width = MW_WORD;
                endcase
        end

endmodule

/* design/ctrl_sequencer.sv */
`timescale 1ns/1ps

module ctrl_sequencer (
        input  logic                              clk,
        input  logic                              reset,
        input  mips_ctrl_pkg::instr_class_t       cls,
        input  mips_ctrl_pkg::alu_op_t            alu_op,
        input  mips_ctrl_pkg::branch_cond_t       branch_cond,
        input  mips_ctrl_pkg::alu_flags_t         flags,
        output mips_ctrl_pkg::ctrl_state_t        state,
        output logic [mips_ctrl_pkg::STEP_W-1:0]  step,
        output mips_ctrl_pkg::exc_cause_t         cause
);
        import mips_ctrl_pkg::*;

        ctrl_state_t state_next;
        exc_cause_t  cause_next;
        logic        taken;
        logic        r_trap;

        // Flags come from the compare selected in this same cycle
        always_comb begin
                case (branch_cond)
                        COND_EQ: taken = flags.eq;
                        COND_NE: taken = !flags.eq;
                        COND_LE: taken = !flags.gt;
                        default: taken = flags.gt;
                endcase
        end

        assign r_trap = flags.overflow && (alu_op == ALU_ADD || alu_op == ALU_SUB);

        always_comb begin
                state_next = state;
                cause_next = cause;
                case (state)
                        ST_FETCH: begin
                                if (step == FETCH_STEPS - 1'b1)
                                        state_next = ST_DECODE;
                        end
                        ST_DECODE: begin
                                if (step == DECODE_STEPS - 1'b1) begin
                                        case (cls)
                                                CLS_R_ALU:     state_next = ST_R_EXEC;
                                                CLS_ADDI,
                                                CLS_ADDIU:     state_next = ST_ADDI_EXEC;
                                                CLS_BRANCH:    state_next = ST_BRANCH_CMP;
                                                CLS_LOAD,
                                                CLS_STORE:     state_next = ST_MEM_ADDR;
                                                CLS_JUMP:      state_next = ST_JUMP;
                                                CLS_JUMP_LINK: state_next = ST_JAL_LINK;
                                                default: begin
                                                        state_next = ST_EXCEPTION;
                                                        cause_next = EXC_INVALID;
                                                end
                                        endcase
                                end
                        end
                        ST_R_EXEC: begin
                                state_next = r_trap ? ST_EXCEPTION : ST_R_WRITE;
                                if (r_trap)
                                        cause_next = EXC_OVERFLOW;
                        end
                        ST_ADDI_EXEC: begin
                                if (cls == CLS_ADDI && flags.overflow) begin  // ADDIU never traps
                                        state_next = ST_EXCEPTION;
                                        cause_next = EXC_OVERFLOW;
                                end else begin
                                        state_next = ST_ADDI_WRITE;
                                end
                        end
                        ST_BRANCH_CMP: state_next = taken ? ST_BRANCH_WRITE : ST_FETCH;
                        ST_MEM_ADDR:   state_next = ST_MEM_WAIT;
                        ST_MEM_WAIT: begin
                                if (step == MEM_WAIT_STEPS - 1'b1)
                                        state_next = (cls == CLS_LOAD) ? ST_LOAD_WRITE
                                                                       : ST_STORE_WRITE;
                        end
                        ST_JAL_LINK:   state_next = ST_JUMP;
                        ST_EXCEPTION: begin
                                if (step == EXC_STEPS - 1'b1)
                                        state_next = ST_FETCH;
                        end
                        default:       state_next = ST_FETCH;  // All single-cycle finals
                endcase
        end

        // Step restarts on every state change
        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= ST_FETCH;
                        step  <= '0;
                        cause <= EXC_INVALID;
                end else begin
                        state <= state_next;
                        step  <= (state_next != state) ? '0 : step + 1'b1;
                        cause <= cause_next;
                end
        end

endmodule

/* design/ctrl_word_gen.sv */
`timescale 1ns/1ps

module ctrl_word_gen (
        input  mips_ctrl_pkg::ctrl_state_t        state,
        input  logic [mips_ctrl_pkg::STEP_W-1:0]  step,
        input  mips_ctrl_pkg::instr_class_t       cls,
        input  mips_ctrl_pkg::alu_op_t            alu_op,
        input  mips_ctrl_pkg::mem_width_t         mem_width,
        input  mips_ctrl_pkg::exc_cause_t         cause,
        output mips_ctrl_pkg::ctrl_word_t         ctrl
);
        import mips_ctrl_pkg::*;

        reg_dst_t dst;

        assign dst = (cls == CLS_R_ALU) ? RD_RD : RD_RT;

        always_comb begin
                // Idle word reads memory at PC and forms PC+4
                ctrl           = '0;
                ctrl.pc_src    = PC_ALU;
                ctrl.alu_src_a = A_PC;
                ctrl.alu_src_b = B_FOUR;
                ctrl.alu_op    = ALU_ADD;
                ctrl.iord      = IORD_PC;
                ctrl.reg_dst   = RD_RT;
                ctrl.reg_data  = DATA_ALU_OUT;
                ctrl.load_ctrl  = MW_WORD;
                ctrl.store_ctrl = MW_WORD;

                case (state)
                        ST_FETCH: begin
                                if (step == FETCH_STEPS - 1'b1) begin
                                        ctrl.ir_write = 1'b1;
                                        ctrl.pc_write = 1'b1;
                                end
                        end
                        ST_DECODE: begin
                                ctrl.alu_src_b = B_OFFSET;             // Early branch target
                                if (step == '0) begin
                                        ctrl.a_write       = 1'b1;
                                        ctrl.b_write       = 1'b1;
                                        ctrl.alu_out_write = 1'b1;
                                end
                        end
                        ST_R_EXEC, ST_ADDI_EXEC, ST_MEM_ADDR: begin
                                ctrl.alu_src_a     = A_REG;
                                ctrl.alu_src_b     = (state == ST_R_EXEC) ? B_REG : B_IMM;
                                ctrl.alu_op        = (state == ST_MEM_ADDR) ? ALU_ADD : alu_op;
                                ctrl.alu_out_write = 1'b1;
                        end
                        ST_R_WRITE, ST_ADDI_WRITE: begin
                                ctrl.bank_write = 1'b1;
                                ctrl.reg_dst    = dst;
                        end
                        ST_BRANCH_CMP: begin
                                ctrl.alu_src_a = A_REG;
                                ctrl.alu_src_b = B_REG;
                                ctrl.alu_op    = alu_op;
                        end
                        ST_BRANCH_WRITE: begin
                                ctrl.pc_src   = PC_ALU_OUT;
                                ctrl.pc_write = 1'b1;
                        end
                        ST_MEM_WAIT: ctrl.iord = IORD_ALU;
                        ST_LOAD_WRITE: begin
                                ctrl.iord          = IORD_ALU;
                                ctrl.load_ctrl     = mem_width;
                                ctrl.bank_write    = 1'b1;
                                ctrl.mem_reg_write = 1'b1;
                                ctrl.reg_dst       = dst;
                                ctrl.reg_data      = DATA_MDR;
                        end
                        ST_STORE_WRITE: begin
                                ctrl.iord       = IORD_ALU;
                                ctrl.store_ctrl = mem_width;
                                ctrl.mem_write  = 1'b1;
                        end
                        ST_JAL_LINK: begin
                                ctrl.bank_write = 1'b1;
                                ctrl.reg_dst    = RD_LINK;
                                ctrl.reg_data   = DATA_PC;       // Return address
                        end
                        ST_JUMP: begin
                                ctrl.pc_src   = PC_JUMP;
                                ctrl.pc_write = 1'b1;
                        end
                        ST_EXCEPTION: begin
                                ctrl.pc_src = PC_LOAD;
                                if (step < EXC_STEPS - 1'b1) begin
                                        // EPC gets PC-4, vector byte read
                                        ctrl.alu_op        = ALU_SUB;
                                        ctrl.iord          = iord_t'(cause);
                                        ctrl.epc_write     = 1'b1;
                                        ctrl.mem_reg_write = 1'b1;
                                end else begin
                                        ctrl.load_ctrl = MW_BYTE;
                                        ctrl.pc_write  = 1'b1;
                                end
                        end
                        default: ;
                endcase
        end

endmodule

/* design/mips_ctrl_top.sv */
`timescale 1ns/1ps

module mips_ctrl_top (
        input  logic                      clk,
        input  logic                      reset,
        input  mips_ctrl_pkg::opcode_t    op,
        input  mips_ctrl_pkg::funct_t     funct,
        input  mips_ctrl_pkg::alu_flags_t flags,
        output mips_ctrl_pkg::ctrl_word_t ctrl
);
        import mips_ctrl_pkg::*;

        instr_class_t        cls;
        alu_op_t             alu_op;
        mem_width_t          mem_width;
        branch_cond_t        branch_cond;
        ctrl_state_t         state;
        logic [STEP_W-1:0]   step;
        exc_cause_t          cause;

        instr_decoder u_decoder (
                .op          (op),
                .funct       (funct),
                .cls         (cls),
                .alu_op      (alu_op),
                .mem_width   (mem_width),
                .branch_cond (branch_cond)
        );

        ctrl_sequencer u_sequencer (
                .clk         (clk),
                .reset       (reset),
                .cls         (cls),
                .alu_op      (alu_op),
                .branch_cond (branch_cond),
                .flags       (flags),
                .state       (state),
                .step        (step),
                .cause       (cause)
        );

        ctrl_word_gen u_word_gen (
                .state       (state),
                .step        (step),
                .cls         (cls),
                .alu_op      (alu_op),
                .mem_width   (mem_width),
                .cause       (cause),
                .ctrl        (ctrl)
        );

endmodule

/* verification/mips_ctrl_assert.sv */
`timescale 1ns/1ps

module mips_ctrl_assert (
        input logic                      clk,
        input logic                      reset,
        input mips_ctrl_pkg::ctrl_word_t ctrl
);
        ir_vs_bank: assert property (@(posedge clk) disable iff (reset)
                !(ctrl.ir_write && ctrl.bank_write))
                else $error("ir_write and bank_write high in the same cycle");

        store_vs_load: assert property (@(posedge clk) disable iff (reset)
                !(ctrl.mem_write && ctrl.mem_reg_write))
                else $error("mem_write high during a load write");

        // EPC write needs a PC load one or two cycles later
        epc_then_pc: assert property (@(posedge clk) disable iff (reset)
                $past(ctrl.epc_write, 2) |-> (ctrl.pc_write || $past(ctrl.pc_write)))
                else $error("epc_write not followed by pc_write within two cycles");
endmodule

bind mips_ctrl_top mips_ctrl_assert u_ctrl_assert (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl)
);

/* include/tb_ctrl_model.svh */
`ifndef TB_CTRL_MODEL_SVH
`define TB_CTRL_MODEL_SVH

ctrl_word_t expected_q[$];     // Words after the fetch pulse

// Idle word reads memory at PC and forms PC+4, no enables
function automatic ctrl_word_t idle_word();
        ctrl_word_t w;
        w            = '0;
        w.pc_src     = PC_ALU;
        w.alu_src_a  = A_PC;
        w.alu_src_b  = B_FOUR;
        w.alu_op     = ALU_ADD;
        w.iord       = IORD_PC;
        w.reg_dst    = RD_RT;
        w.reg_data   = DATA_ALU_OUT;
        w.load_ctrl  = MW_WORD;
        w.store_ctrl = MW_WORD;
        return w;
endfunction

function automatic ctrl_word_t fetch_word(input int step);
        ctrl_word_t w;
        w = idle_word();
        if (step == int'(FETCH_STEPS) - 1) begin
                w.ir_write = 1'b1;
                w.pc_write = 1'b1;
        end
        return w;
endfunction

function automatic ctrl_word_t exec_word(input alu_src_b_t src_b, input alu_op_t aop);
        ctrl_word_t w;
        w               = idle_word();
        w.alu_src_a     = A_REG;
        w.alu_src_b     = src_b;
        w.alu_op        = aop;
        w.alu_out_write = 1'b1;
        return w;
endfunction

function automatic ctrl_word_t bank_word(input reg_dst_t dst, input reg_data_t data);
        ctrl_word_t w;
        w            = idle_word();
        w.bank_write = 1'b1;
        w.reg_dst    = dst;
        w.reg_data   = data;
        return w;
endfunction

function automatic ctrl_word_t pc_word(input pc_src_t src);
        ctrl_word_t w;
        w          = idle_word();
        w.pc_src   = src;
        w.pc_write = 1'b1;
        return w;
endfunction

function automatic logic branch_taken(input opcode_t op, input alu_flags_t fl);
        case (op)
                OP_BEQ:  return fl.eq;
                OP_BNE:  return !fl.eq;
                OP_BLE:  return !fl.gt;
                default: return fl.gt;
        endcase
endfunction

function automatic mem_width_t width_of(input opcode_t op);
        case (op)
                OP_LB, OP_SB: return MW_BYTE;
                OP_LH, OP_SH: return MW_HALF;
                default:      return MW_WORD;
        endcase
endfunction

// EPC and vector read, then PC loads from the vector byte
task automatic push_exception(input iord_t vec);
        ctrl_word_t w;
        for (int i = 0; i < int'(EXC_STEPS); i++) begin
                w        = idle_word();
                w.pc_src = PC_LOAD;
                if (i < int'(EXC_STEPS) - 1) begin
                        w.alu_op        = ALU_SUB;
                        w.iord          = vec;
                        w.epc_write     = 1'b1;
                        w.mem_reg_write = 1'b1;
                end else begin
                        w.load_ctrl = MW_BYTE;
                        w.pc_write  = 1'b1;
                end
                expected_q.push_back(w);
        end
endtask

task automatic build_expected(input opcode_t op, input funct_t fn, input alu_flags_t fl);
        ctrl_word_t w;
        alu_op_t    aop;
        logic       fn_ok;
        expected_q.delete();
        w               = idle_word();
        w.alu_src_b     = B_OFFSET;         // Branch target computed early
        w.a_write       = 1'b1;
        w.b_write       = 1'b1;
        w.alu_out_write = 1'b1;
        expected_q.push_back(w);
        w = idle_word();
        w.alu_src_b = B_OFFSET;
        expected_q.push_back(w);
        case (op)
                OP_RTYPE: begin
                        fn_ok = 1'b1;
                        aop   = ALU_ADD;
                        case (fn)
                                FN_ADD:  aop = ALU_ADD;
                                FN_SUB:  aop = ALU_SUB;
                                FN_AND:  aop = ALU_AND;
                                FN_SLT:  aop = ALU_SLT;
                                default: fn_ok = 1'b0;
                        endcase
                        if (!fn_ok) begin
                                push_exception(IORD_VEC_INV);
                        end else begin
                                expected_q.push_back(exec_word(B_REG, aop));
                                if (fl.overflow && (fn == FN_ADD || fn == FN_SUB))
                                        push_exception(IORD_VEC_OVF);
                                else
                                        expected_q.push_back(bank_word(RD_RD, DATA_ALU_OUT));
                        end
                end
                OP_ADDI, OP_ADDIU: begin
                        expected_q.push_back(exec_word(B_IMM, ALU_ADD));
                        if (op == OP_ADDI && fl.overflow)     // ADDIU ignores overflow
                                push_exception(IORD_VEC_OVF);
                        else
                                expected_q.push_back(bank_word(RD_RT, DATA_ALU_OUT));
                end
                OP_BEQ, OP_BNE, OP_BLE, OP_BGT: begin
                        w = idle_word();
                        w.alu_src_a = A_REG;
                        w.alu_src_b = B_REG;
                        w.alu_op    = ALU_CMP;
                        expected_q.push_back(w);
                        if (branch_taken(op, fl))
                                expected_q.push_back(pc_word(PC_ALU_OUT));
                end
                OP_LB, OP_LH, OP_LW, OP_SB, OP_SH, OP_SW: begin
                        expected_q.push_back(exec_word(B_IMM, ALU_ADD));
                        w = idle_word();
                        w.iord = IORD_ALU;
                        for (int i = 0; i < int'(MEM_WAIT_STEPS); i++)
                                expected_q.push_back(w);
                        if (op == OP_LB || op == OP_LH || op == OP_LW) begin
                                w               = bank_word(RD_RT, DATA_MDR);
                                w.iord          = IORD_ALU;
                                w.load_ctrl     = width_of(op);
                                w.mem_reg_write = 1'b1;
                        end else begin
                                w.store_ctrl = width_of(op);
                                w.mem_write  = 1'b1;
                        end
                        expected_q.push_back(w);
                end
                OP_J: expected_q.push_back(pc_word(PC_JUMP));
                OP_JAL: begin
                        expected_q.push_back(bank_word(RD_LINK, DATA_PC));
                        expected_q.push_back(pc_word(PC_JUMP));
                end
                default: push_exception(IORD_VEC_INV);
        endcase
endtask

`endif

/* verification/tb_mips_ctrl.sv */
`timescale 1ns/1ps

module tb_mips_ctrl;
        import mips_ctrl_pkg::*;

        localparam int NUM_INSTR     = 300;
        localparam int FETCH_TIMEOUT = 20;    // Cycles allowed before the IR load

        logic        clk;
        logic        reset;
        opcode_t     op;
        funct_t      funct;
        alu_flags_t  flags;
        ctrl_word_t  ctrl;
        logic [31:0] lcg_state;
        int          instr_num;

        opcode_t valid_ops [15] = '{OP_RTYPE, OP_ADDI, OP_ADDIU, OP_BEQ, OP_BNE, OP_BLE,
                                    OP_BGT, OP_LB, OP_LH, OP_LW, OP_SB, OP_SH, OP_SW,
                                    OP_J, OP_JAL};
        funct_t  valid_fns [4] = '{FN_ADD, FN_SUB, FN_AND, FN_SLT};
        logic [5:0] bad_ops [4] = '{6'h01, 6'h0c, 6'h1f, 6'h3f};
        logic [5:0] bad_fns [4] = '{6'h00, 6'h08, 6'h18, 6'h25};

        `include "tb_ctrl_model.svh"

        mips_ctrl_top u_dut (
                .clk   (clk),
                .reset (reset),
                .op    (op),
                .funct (funct),
                .flags (flags),
                .ctrl  (ctrl)
        );

        always #20 clk = ~clk;

        function automatic logic [31:0] next_random();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return {16'd0, lcg_state[31:16]};     // Upper half is better mixed
        endfunction

        function automatic int pick_index(input int n);
                return int'(next_random() % n);
        endfunction

        task automatic pick_instruction(output opcode_t p_op, output funct_t p_fn,
                                        output alu_flags_t p_fl);
                logic [31:0] r;
                r    = next_random();
                p_fl = r[2:0];
                p_fn = valid_fns[pick_index(4)];
                if (pick_index(100) < 10) begin
                        if (r[8]) begin
                                p_op = OP_RTYPE;                      // Unknown funct
                                p_fn = funct_t'(bad_fns[pick_index(4)]);
                        end else begin
                                p_op = opcode_t'(bad_ops[pick_index(4)]);
                        end
                end else begin
                        p_op = valid_ops[pick_index(15)];
                end
        endtask

        task automatic fail_now(input string why);
                $display("%s", why);
                $display("RESULT: FAIL");
                $fatal(1, "simulation stopped at first error");
        endtask

        task automatic check_ctrl(input ctrl_word_t expected, input ctrl_word_t actual);
                if (actual !== expected)
                        fail_now($sformatf(
                                "mismatch ctrl: expected 0x%h, actual 0x%h (instr %0d, op 0x%h)",
                                expected, actual, instr_num, op));
        endtask

        task automatic wait_fetch_pulse();
                int cycles;
                cycles = 0;
                do begin
                        @(negedge clk);
                        check_ctrl(fetch_word(cycles), ctrl);
                        cycles++;
                        if (cycles > FETCH_TIMEOUT)
                                fail_now("timeout: the fetch pulse never came");
                end while (!ctrl.ir_write);
        endtask

        task automatic check_instruction();
                ctrl_word_t expected;
                while (expected_q.size() > 0) begin
                        expected = expected_q.pop_front();
                        @(negedge clk);
                        check_ctrl(expected, ctrl);
                end
        endtask

        initial begin
                opcode_t    next_op;
                funct_t     next_fn;
                alu_flags_t next_fl;
                clk       = 1'b0;
                reset     = 1'b1;
                op        = OP_RTYPE;
                funct     = FN_ADD;
                flags     = '0;
                lcg_state = 32'd50183;
                instr_num = 0;
                repeat (15) @(posedge clk);
                @(negedge clk);
                check_ctrl(fetch_word(0), ctrl);      // Idle word under reset
                @(posedge clk);
                reset <= 1'b0;

                for (instr_num = 0; instr_num < NUM_INSTR; instr_num++) begin
                        pick_instruction(next_op, next_fn, next_fl);
                        build_expected(next_op, next_fn, next_fl);
                        wait_fetch_pulse();
                        @(posedge clk);
                        op    <= next_op;                     // IR loads on this edge
                        funct <= next_fn;
                        flags <= next_fl;
                        check_instruction();
                end
                wait_fetch_pulse();                           // Last instruction returns to FETCH

                $display("RESULT: PASS");
                $finish;
        end

endmodule

/* src.f */
+incdir+include
design/mips_ctrl_pkg.sv
design/instr_decoder.sv
design/ctrl_sequencer.sv
design/ctrl_word_gen.sv
design/mips_ctrl_top.sv
verification/mips_ctrl_assert.sv
verification/tb_mips_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_mips_ctrl -f src.f -o sim_mips_ctrl \
        && ./obj_dir/sim_mips_ctrl 2>&1 | tee sim.log
[ -f sim.log ] || { echo "build failed"; exit 1; }
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
